/* hdl/secv_pkg.sv */
// SEC-V execute cluster definitions
package secv_pkg;

    // Core widths
    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Major opcodes handled by the cluster
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,  // Register-register ALU
        OPCODE_OPIMM  = 7'b0010011,  // Register-immediate ALU
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } opcode_t;

    typedef logic [2:0] funct3_t;

    // ALU variants
    localparam funct3_t F3_ADD  = 3'b000;  // ADD, SUB
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // SRL, SRA
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch variants, 010 and 011 do not exist
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;
    localparam funct3_t F3_JALR = 3'b000;  // Only encoding of JALR

    typedef logic [31:0] imm_t;  // Immediate, sign already spread to bit 31

    // Instruction formats, all ILEN bits wide
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]           imm_11_0;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]            imm_11_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [4:0]            imm_4_0;
        opcode_t               opcode;
    } s_type_t;

    typedef struct packed {
        logic                  imm_12;
        logic [5:0]            imm_10_5;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [3:0]            imm_4_1;
        logic                  imm_11;
        opcode_t               opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]           imm_31_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } u_type_t;

    typedef struct packed {
        logic                  imm_20;
        logic [9:0]            imm_10_1;
        logic                  imm_11;
        logic [7:0]            imm_19_12;
        logic [REG_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } inst_t;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_MOVE,
        UNIT_BRANCH
    } unit_t;

    // Write-back bundle into the register file
    typedef struct packed {
        logic [XLEN-1:0]       data;
        logic [REG_ADDR_W-1:0] addr;
        logic                  wb;
    } result_t;

    // Widen a 32-bit immediate to XLEN
    function automatic logic [XLEN-1:0] sext32(input imm_t imm);
        return XLEN'(signed'(imm));
    endfunction

endpackage

/* hdl/decode.sv */
// Instruction decoder
`timescale 1ns/1ps

module decode #(
    parameter int XLEN = secv_pkg::XLEN,
    parameter int ILEN = secv_pkg::ILEN
) (
    input  secv_pkg::inst_t                  inst_i,
    output secv_pkg::unit_t                  unit_o,     // Target function unit
    output logic [secv_pkg::REG_ADDR_W-1:0]  rs1_o,
    output logic [secv_pkg::REG_ADDR_W-1:0]  rs2_o,
    output logic [secv_pkg::REG_ADDR_W-1:0]  rd_o,
    output secv_pkg::imm_t                   imm_o,
    output logic                             illegal_o   // Unknown opcode or funct3
);

    secv_pkg::opcode_t opcode;
    secv_pkg::funct3_t funct3;
    logic              sgn;  // Immediate sign, always the top instruction bit
    secv_pkg::imm_t    imm_i_fmt, imm_b_fmt, imm_u_fmt, imm_j_fmt;

    assign opcode = inst_i.r_type.opcode;
    assign funct3 = inst_i.r_type.funct3;
    assign sgn    = inst_i[ILEN-1];

    // Register fields sit at fixed positions in every format
    assign rs1_o = inst_i.r_type.rs1;
    assign rs2_o = inst_i.r_type.rs2;
    assign rd_o  = inst_i.r_type.rd;

    // Immediate layouts
    assign imm_i_fmt = {{20{sgn}}, inst_i.i_type.imm_11_0};
    assign imm_b_fmt = {{20{sgn}}, inst_i.b_type.imm_11, inst_i.b_type.imm_10_5,
                        inst_i.b_type.imm_4_1, 1'b0};
    assign imm_u_fmt = {inst_i.u_type.imm_31_12, 12'b0};
    assign imm_j_fmt = {{12{sgn}}, inst_i.j_type.imm_19_12, inst_i.j_type.imm_11,
                        inst_i.j_type.imm_10_1, 1'b0};

    always_comb begin
        unit_o    = secv_pkg::UNIT_NONE;
        imm_o     = '0;
        illegal_o = 1'b0;
        case (opcode)
            secv_pkg::OPCODE_OP:     unit_o = secv_pkg::UNIT_ALU;  // No immediate
            secv_pkg::OPCODE_OPIMM: begin
                unit_o = secv_pkg::UNIT_ALU;
                imm_o  = imm_i_fmt;
            end
            secv_pkg::OPCODE_LUI, secv_pkg::OPCODE_AUIPC: begin
                unit_o = secv_pkg::UNIT_MOVE;
                imm_o  = imm_u_fmt;
            end
            secv_pkg::OPCODE_JAL: begin
                unit_o = secv_pkg::UNIT_BRANCH;
                imm_o  = imm_j_fmt;
            end
            secv_pkg::OPCODE_JALR: begin
                imm_o = imm_i_fmt;
                if (funct3 == secv_pkg::F3_JALR) unit_o = secv_pkg::UNIT_BRANCH;
                else illegal_o = 1'b1;
            end
            secv_pkg::OPCODE_BRANCH: begin
                imm_o = imm_b_fmt;
                if (funct3 == 3'b010 || funct3 == 3'b011) illegal_o = 1'b1;  // Holes
                else unit_o = secv_pkg::UNIT_BRANCH;
            end
            default: illegal_o = 1'b1;
        endcase
    end

    // An illegal word must never reach a unit
    always_comb begin
        assert final (!(illegal_o && unit_o != secv_pkg::UNIT_NONE))
            else $error("decode: illegal instruction routed to a unit");
    end

endmodule

/* hdl/regfile.sv */
// Integer register file
`timescale 1ns/1ps

module regfile #(
    parameter int XLEN = secv_pkg::XLEN
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic [secv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [secv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]                 rdata1_o,
    output logic [XLEN-1:0]                 rdata2_o,
    input  secv_pkg::result_t               wr_i       // Write port
);

    localparam int NREGS = 2 ** secv_pkg::REG_ADDR_W;

    logic [XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wb && wr_i.addr != '0) begin  // x0 is read-only
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // Combinational reads, x0 forced to zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // Writes to x0 must never stick
    a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i) regs[0] == '0)
        else $error("regfile: x0 holds a nonzero value");

endmodule

/* hdl/alu.sv */
// Integer ALU function unit
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = secv_pkg::XLEN,
    parameter int ILEN = secv_pkg::ILEN
) (
    input  secv_pkg::inst_t  inst_i,
    input  logic             ena_i,
    output logic             rdy_o,
    output logic             err_o,   // Nonexistent funct7
    input  logic [XLEN-1:0]  rs1_i,
    input  logic [XLEN-1:0]  rs2_i,
    input  secv_pkg::imm_t   imm_i,   // I-type immediate
    output logic [XLEN-1:0]  rd_o,
    output logic             rd_wb_o
);

    localparam int SHW = $clog2(XLEN);

    secv_pkg::opcode_t opcode;
    secv_pkg::funct3_t funct3;
    logic [6:0]        funct7;
    logic              is_op, is_opimm;
    logic              f7_zero, f7_alt;
    logic [XLEN-1:0]   op_b;
    logic [SHW-1:0]    shamt;

    if (ILEN != $bits(secv_pkg::inst_t)) begin : g_ilen_chk
        $error("alu: ILEN does not match the instruction type");
    end

    assign opcode   = inst_i.r_type.opcode;
    assign funct3   = inst_i.r_type.funct3;
    assign funct7   = inst_i.r_type.funct7;
    assign is_op    = (opcode == secv_pkg::OPCODE_OP);
    assign is_opimm = (opcode == secv_pkg::OPCODE_OPIMM);
    assign f7_zero  = (funct7 == 7'b0000000);
    assign f7_alt   = (funct7 == 7'b0100000);  // Bit 30 set, SUB or SRA

    assign op_b  = is_op ? rs2_i : secv_pkg::sext32(imm_i);  // Second operand
    assign shamt = op_b[SHW-1:0];

    always_comb begin
        rd_o  = '0;
        err_o = is_op && !f7_zero;  // Most R-type ops allow funct7 zero only
        case (funct3)
            secv_pkg::F3_ADD: begin
                if (is_op && f7_alt) rd_o = rs1_i - op_b;
                else rd_o = rs1_i + op_b;
                err_o = is_op && !(f7_zero || f7_alt);
            end
            secv_pkg::F3_SLL: begin
                rd_o  = rs1_i << shamt;
                err_o = !f7_zero;  // Also checks SLLI upper bits
            end
            secv_pkg::F3_SLT:  rd_o = XLEN'($signed(rs1_i) < $signed(op_b));
            secv_pkg::F3_SLTU: rd_o = XLEN'(rs1_i < op_b);
            secv_pkg::F3_XOR:  rd_o = rs1_i ^ op_b;
            secv_pkg::F3_SR: begin
                if (f7_alt) rd_o = $signed(rs1_i) >>> shamt;  // Arithmetic
                else rd_o = rs1_i >> shamt;
                err_o = !(f7_zero || f7_alt);
            end
            secv_pkg::F3_OR:   rd_o = rs1_i | op_b;
            default:           rd_o = rs1_i & op_b;  // F3_AND
        endcase
    end

    assign rd_wb_o = (is_op || is_opimm) && !err_o;
    assign rdy_o   = ena_i;  // Single cycle, always ready

endmodule

/* hdl/move.sv */
// Move function unit
`timescale 1ns/1ps

module move #(
    parameter int XLEN = secv_pkg::XLEN,
    parameter int ILEN = secv_pkg::ILEN
) (
    input  secv_pkg::inst_t  inst_i,
    input  logic             ena_i,
    output logic             rdy_o,
    output logic             err_o,
    input  logic [XLEN-1:0]  pc_i,
    input  secv_pkg::imm_t   imm_i,   // U-type immediate
    output logic [XLEN-1:0]  rd_o,
    output logic             rd_wb_o
);

    secv_pkg::opcode_t opcode;
    logic [XLEN-1:0]   sext_imm;

    if (ILEN != $bits(secv_pkg::inst_t)) begin : g_ilen_chk
        $error("move: ILEN does not match the instruction type");
    end

    assign opcode   = inst_i.u_type.opcode;
    assign sext_imm = secv_pkg::sext32(imm_i);

    always_comb begin
        rd_o    = '0;
        rd_wb_o = 1'b0;
        if (opcode == secv_pkg::OPCODE_LUI) begin
            rd_o    = sext_imm;         // Upper immediate as is
            rd_wb_o = 1'b1;
        end else if (opcode == secv_pkg::OPCODE_AUIPC) begin
            rd_o    = pc_i + sext_imm;  // PC-relative
            rd_wb_o = 1'b1;
        end
    end

    assign rdy_o = ena_i;
    assign err_o = 1'b0;  // Nothing can fail here

endmodule

/* hdl/branch.sv */
// Branch and jump function unit
`timescale 1ns/1ps

module branch #(
    parameter int XLEN = secv_pkg::XLEN,
    parameter int ILEN = secv_pkg::ILEN
) (
    input  secv_pkg::inst_t  inst_i,
    input  logic             ena_i,
    output logic             rdy_o,
    output logic             err_o,   // Misaligned target
    input  logic [XLEN-1:0]  pc_i,
    input  logic [XLEN-1:0]  rs1_i,
    input  logic [XLEN-1:0]  rs2_i,
    input  secv_pkg::imm_t   imm_i,   // B, J or I immediate
    output logic [XLEN-1:0]  rd_o,    // Link value
    output logic             rd_wb_o,
    output logic [XLEN-1:0]  npc_o
);

    secv_pkg::opcode_t opcode;
    secv_pkg::funct3_t funct3;
    logic [XLEN-1:0]   sext_imm, pc4, jalr_sum;
    logic              taken;

    if (ILEN != $bits(secv_pkg::inst_t)) begin : g_ilen_chk
        $error("branch: ILEN does not match the instruction type");
    end

    assign opcode   = inst_i.b_type.opcode;
    assign funct3   = inst_i.b_type.funct3;
    assign sext_imm = secv_pkg::sext32(imm_i);
    assign pc4      = pc_i + XLEN'(4);
    assign jalr_sum = rs1_i + sext_imm;

    // Condition evaluation
    always_comb begin
        case (funct3)
            secv_pkg::F3_BEQ:  taken = (rs1_i == rs2_i);
            secv_pkg::F3_BNE:  taken = (rs1_i != rs2_i);
            secv_pkg::F3_BLT:  taken = ($signed(rs1_i) < $signed(rs2_i));
            secv_pkg::F3_BGE:  taken = ($signed(rs1_i) >= $signed(rs2_i));
            secv_pkg::F3_BLTU: taken = (rs1_i < rs2_i);
            secv_pkg::F3_BGEU: taken = (rs1_i >= rs2_i);
            default:           taken = 1'b0;  // Decoder rejects these
        endcase
    end

    // Next PC and link
    always_comb begin
        npc_o   = pc4;
        rd_wb_o = 1'b0;
        case (opcode)
            secv_pkg::OPCODE_JAL: begin
                npc_o   = pc_i + sext_imm;
                rd_wb_o = 1'b1;
            end
            secv_pkg::OPCODE_JALR: begin
                npc_o   = {jalr_sum[XLEN-1:1], 1'b0};  // LSB dropped
                rd_wb_o = 1'b1;
            end
            secv_pkg::OPCODE_BRANCH: if (taken) npc_o = pc_i + sext_imm;
            default: ;
        endcase
    end

    assign rd_o  = pc4;       // Return address
    assign err_o = npc_o[1];  // Targets must be word aligned
    assign rdy_o = ena_i;

endmodule

/* hdl/secv_exec.sv */
// SEC-V execute cluster
`timescale 1ns/1ps

module secv_exec #(
    parameter int XLEN = secv_pkg::XLEN,
    parameter int ILEN = secv_pkg::ILEN
) (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            ena_i,      // Instruction valid strobe
    input  secv_pkg::inst_t                 inst_i,
    input  logic [XLEN-1:0]                 pc_i,
    output logic                            rdy_o,
    output logic                            wb_en_o,    // One-cycle pulse
    output logic [secv_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [XLEN-1:0]                 wb_data_o,
    output logic [XLEN-1:0]                 npc_o,
    output logic                            err_o
);

    secv_pkg::unit_t                 unit;
    logic [secv_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
    secv_pkg::imm_t                  imm;
    logic                            illegal;
    logic [XLEN-1:0]                 rdata1, rdata2;
    logic                            alu_ena, alu_rdy, alu_err, alu_wb;
    logic                            mov_ena, mov_rdy, mov_err, mov_wb;
    logic                            br_ena, br_rdy, br_err, br_wb;
    logic [XLEN-1:0]                 alu_rd, mov_rd, br_rd, br_npc;
    logic [XLEN-1:0]                 sel_npc;
    logic                            sel_err;
    secv_pkg::result_t               wr;

    decode #(.XLEN(XLEN), .ILEN(ILEN)) u_decode (
        .inst_i, .unit_o(unit), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .imm_o(imm), .illegal_o(illegal)
    );

    regfile #(.XLEN(XLEN)) u_regfile (
        .clk_i, .rst_i, .raddr1_i(rs1), .raddr2_i(rs2),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .wr_i(wr)
    );

    // One unit enabled, and only on a valid strobe
    assign alu_ena = ena_i && (unit == secv_pkg::UNIT_ALU);
    assign mov_ena = ena_i && (unit == secv_pkg::UNIT_MOVE);
    assign br_ena  = ena_i && (unit == secv_pkg::UNIT_BRANCH);

    alu #(.XLEN(XLEN), .ILEN(ILEN)) u_alu (
        .inst_i, .ena_i(alu_ena), .rdy_o(alu_rdy), .err_o(alu_err),
        .rs1_i(rdata1), .rs2_i(rdata2), .imm_i(imm), .rd_o(alu_rd), .rd_wb_o(alu_wb)
    );

    move #(.XLEN(XLEN), .ILEN(ILEN)) u_move (
        .inst_i, .ena_i(mov_ena), .rdy_o(mov_rdy), .err_o(mov_err),
        .pc_i, .imm_i(imm), .rd_o(mov_rd), .rd_wb_o(mov_wb)
    );

    branch #(.XLEN(XLEN), .ILEN(ILEN)) u_branch (
        .inst_i, .ena_i(br_ena), .rdy_o(br_rdy), .err_o(br_err), .pc_i,
        .rs1_i(rdata1), .rs2_i(rdata2), .imm_i(imm),
        .rd_o(br_rd), .rd_wb_o(br_wb), .npc_o(br_npc)
    );

    // Result steering
    always_comb begin
        wr.data = '0;
        wr.addr = rd;
        wr.wb   = 1'b0;
        sel_npc = pc_i + XLEN'(4);  // Fall-through for non-branch units
        sel_err = illegal;
        case (unit)
            secv_pkg::UNIT_ALU: begin
                wr.data = alu_rd;
                wr.wb   = alu_wb;
                sel_err = alu_err;
            end
            secv_pkg::UNIT_MOVE: begin
                wr.data = mov_rd;
                wr.wb   = mov_wb;
                sel_err = mov_err;
            end
            secv_pkg::UNIT_BRANCH: begin
                wr.data = br_rd;
                wr.wb   = br_wb;
                sel_err = br_err;
                sel_npc = br_npc;
            end
            default: ;
        endcase
        wr.wb = wr.wb && ena_i && !sel_err;  // Faulting instructions write nothing
    end

    assign rdy_o = alu_rdy | mov_rdy | br_rdy;

    // Write-back and next-PC register
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_en_o   <= 1'b0;
            err_o     <= 1'b0;
            wb_addr_o <= '0;
            wb_data_o <= '0;
            npc_o     <= '0;
        end else begin
            wb_en_o <= wr.wb;
            err_o   <= ena_i && sel_err;
            if (ena_i) begin
                wb_addr_o <= wr.addr;
                wb_data_o <= wr.data;
                npc_o     <= sel_npc;
            end
        end
    end

    a_one_unit: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({alu_ena, mov_ena, br_ena}))
        else $error("secv_exec: more than one unit enabled");

endmodule

/* sim/tb_secv_exec.sv */
// Execute cluster testbench
`timescale 1ns/1ps

module tb_secv_exec;

    localparam int XLEN    = 32;
    localparam int TIMEOUT = 20;  // Cycles per wait loop

    logic            clk_i, rst_i, ena_i;
    logic [31:0]     inst_i;
    logic [XLEN-1:0] pc_i;
    logic            rdy_o, wb_en_o, err_o;
    logic [4:0]      wb_addr_o;
    logic [XLEN-1:0] wb_data_o, npc_o;

    logic [XLEN-1:0] model [32];  // Reference register contents
    logic [XLEN-1:0] pc_now;      // PC of the next instruction

    // Expected response of the instruction in flight
    logic            pend_valid, pend_err, pend_wb;
    logic [4:0]      pend_addr;
    logic [XLEN-1:0] pend_data, pend_npc;

    secv_exec #(.XLEN(XLEN), .ILEN(32)) dut (
        .clk_i, .rst_i, .ena_i, .inst_i, .pc_i, .rdy_o,
        .wb_en_o, .wb_addr_o, .wb_data_o, .npc_o, .err_o
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    task automatic check_eq(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("TEST FAIL");
        $fatal(1, "%s", why);
    endtask

    // Instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, secv_pkg::OPCODE_OP};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], secv_pkg::OPCODE_BRANCH};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, secv_pkg::OPCODE_JAL};
    endfunction

    // Reference ALU behavior
    function automatic logic [XLEN-1:0] alu_expect(input logic [2:0] f3, input logic alt,
            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt) r = $signed(a) >>> b[4:0];  // Sign fill
                else r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
            input logic [XLEN-1:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Checks the response registered at the previous edge
    task automatic compare_pending();
        if (pend_valid) begin
            check_eq("err_o", err_o, pend_err);
            check_eq("wb_en_o", wb_en_o, pend_wb);
            if (pend_wb) begin
                check_eq("wb_addr_o", wb_addr_o, pend_addr);
                check_eq("wb_data_o", wb_data_o, pend_data);
            end
            if (!pend_err) check_eq("npc_o", npc_o, pend_npc);
        end else begin
            check_eq("wb_en_o", wb_en_o, 1'b0);  // Idle cycle
            check_eq("err_o", err_o, 1'b0);
        end
        pend_valid = 1'b0;
    endtask

    // One instruction per cycle, checked one cycle later
    task automatic issue(input logic [31:0] word, input logic legal, input logic wb,
            input logic [4:0] addr, input logic [XLEN-1:0] data, input logic [XLEN-1:0] npc);
        ena_i  <= 1'b1;
        inst_i <= word;
        pc_i   <= pc_now;
        @(negedge clk_i);
        compare_pending();
        check_eq("rdy_o", rdy_o, legal);
        pend_valid = 1'b1;
        pend_err   = !legal;
        pend_wb    = wb;
        pend_addr  = addr;
        pend_data  = data;
        pend_npc   = npc;
        pc_now     = legal ? npc : pc_now + 4;  // Follow program flow
        @(posedge clk_i);
    endtask

    task automatic idle();
        ena_i <= 1'b0;
        @(negedge clk_i);
        compare_pending();
        @(posedge clk_i);
    endtask

    task automatic wait_outputs_idle();
        int cycles;
        cycles = 0;
        while (wb_en_o !== 1'b0 || err_o !== 1'b0) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT) abort_run("outputs did not clear after reset");
        end
    endtask

    task automatic write_model(input logic [4:0] rd, input logic [XLEN-1:0] v);
        if (rd != 5'd0) model[rd] = v;  // x0 stays zero
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        logic [XLEN-1:0] res;
        res = alu_expect(f3, alt, model[rs1], model[rs2]);
        issue(r_word(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), 1'b1, 1'b1, rd, res, pc_now + 4);
        write_model(rd, res);
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
            input logic [4:0] rs1);
        logic [XLEN-1:0] res;
        res = alu_expect(f3, f3 == 3'd5 && imm[10], model[rs1], {{20{imm[11]}}, imm});
        issue(i_word(imm, rs1, f3, rd, secv_pkg::OPCODE_OPIMM), 1'b1, 1'b1, rd, res,
              pc_now + 4);
        write_model(rd, res);
    endtask

    task automatic lui(input logic [4:0] rd, input logic [19:0] imm);
        issue({imm, rd, secv_pkg::OPCODE_LUI}, 1'b1, 1'b1, rd, {imm, 12'b0}, pc_now + 4);
        write_model(rd, {imm, 12'b0});
    endtask

    task automatic auipc(input logic [4:0] rd, input logic [19:0] imm);
        logic [XLEN-1:0] res;
        res = pc_now + {imm, 12'b0};
        issue({imm, rd, secv_pkg::OPCODE_AUIPC}, 1'b1, 1'b1, rd, res, pc_now + 4);
        write_model(rd, res);
    endtask

    task automatic cond_branch(input logic [2:0] f3, input logic [4:0] rs1,
            input logic [4:0] rs2, input logic [12:0] off);
        logic [XLEN-1:0] tgt;
        tgt = pc_now + 4;
        if (branch_taken(f3, model[rs1], model[rs2])) tgt = pc_now + {{19{off[12]}}, off};
        issue(b_word(off, rs2, rs1, f3), 1'b1, 1'b0, 5'd0, '0, tgt);  // Never writes
    endtask

    task automatic jal(input logic [4:0] rd, input logic [20:0] off);
        logic [XLEN-1:0] link;
        link = pc_now + 4;
        issue(j_word(off, rd), 1'b1, 1'b1, rd, link, pc_now + {{11{off[20]}}, off});
        write_model(rd, link);
    endtask

    task automatic jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] off);
        logic [XLEN-1:0] link, tgt;
        link = pc_now + 4;
        tgt  = model[rs1] + {{20{off[11]}}, off};
        tgt[0] = 1'b0;
        issue(i_word(off, rs1, 3'd0, rd, secv_pkg::OPCODE_JALR), 1'b1, 1'b1, rd, link, tgt);
        write_model(rd, link);
    endtask

    task automatic test_reset();
        alu_reg(3'd0, 1'b0, 5'd0, 5'd0, 5'd0);  // ADD x0, x0, x0
        idle();
    endtask

    task automatic test_move();
        pc_now = 32'h0000_1000;
        lui(5'd1, 20'h12345);
        lui(5'd2, 20'hFFFFF);    // Negative upper immediate
        auipc(5'd3, 20'h00010);
        auipc(5'd4, 20'hFFFFF);  // Wraps below the PC
        idle();
    endtask

    task automatic test_alu();
        alu_imm(3'd0, 12'd100, 5'd1, 5'd0);
        alu_imm(3'd0, 12'hFF9, 5'd2, 5'd0);  // -7
        alu_imm(3'd0, 12'h7FF, 5'd3, 5'd0);
        alu_imm(3'd0, 12'd3, 5'd7, 5'd0);
        alu_reg(3'd0, 1'b1, 5'd4, 5'd1, 5'd2);   // SUB
        alu_reg(3'd0, 1'b0, 5'd5, 5'd4, 5'd3);   // Uses x4 from the cycle before
        alu_reg(3'd1, 1'b0, 5'd6, 5'd5, 5'd7);
        alu_reg(3'd5, 1'b0, 5'd8, 5'd2, 5'd7);   // SRL of a negative value
        alu_reg(3'd5, 1'b1, 5'd9, 5'd2, 5'd7);   // SRA
        alu_reg(3'd2, 1'b0, 5'd10, 5'd2, 5'd1);
        alu_reg(3'd3, 1'b0, 5'd11, 5'd2, 5'd1);  // Unsigned view flips it
        alu_reg(3'd4, 1'b0, 5'd12, 5'd1, 5'd2);
        alu_reg(3'd6, 1'b0, 5'd13, 5'd12, 5'd3);
        alu_reg(3'd7, 1'b0, 5'd14, 5'd13, 5'd2);
        alu_imm(3'd1, 12'd4, 5'd15, 5'd1);
        alu_imm(3'd5, 12'h401, 5'd16, 5'd2);      // SRAI by 1
        alu_imm(3'd4, 12'hFFF, 5'd17, 5'd2);
        alu_imm(3'd2, 12'd5, 5'd18, 5'd2);
        alu_imm(3'd3, 12'hFFF, 5'd19, 5'd1);
        alu_imm(3'd7, 12'h0F0, 5'd20, 5'd17);
        alu_imm(3'd6, 12'h00F, 5'd21, 5'd20);
        idle();
    endtask

    task automatic test_branch();
        pc_now = 32'h0000_0100;
        alu_imm(3'd0, 12'd5, 5'd1, 5'd0);
        alu_imm(3'd0, 12'hFFD, 5'd2, 5'd0);  // -3
        alu_imm(3'd0, 12'd5, 5'd3, 5'd0);
        cond_branch(3'd0, 5'd1, 5'd3, 13'h0040);  // BEQ taken
        cond_branch(3'd0, 5'd1, 5'd2, 13'h1FF0);
        cond_branch(3'd1, 5'd1, 5'd2, 13'h1FF0);  // BNE taken
        cond_branch(3'd1, 5'd1, 5'd3, 13'h0040);
        cond_branch(3'd4, 5'd2, 5'd1, 13'h0040);  // BLT taken
        cond_branch(3'd4, 5'd1, 5'd2, 13'h0040);
        cond_branch(3'd5, 5'd1, 5'd2, 13'h1FF0);  // BGE taken
        cond_branch(3'd5, 5'd2, 5'd1, 13'h1FF0);
        cond_branch(3'd6, 5'd1, 5'd2, 13'h0040);  // BLTU taken
        cond_branch(3'd6, 5'd2, 5'd1, 13'h0040);
        cond_branch(3'd7, 5'd2, 5'd1, 13'h1FF0);  // BGEU taken
        cond_branch(3'd7, 5'd1, 5'd2, 13'h1FF0);
        jal(5'd5, 21'h000800);
        alu_imm(3'd0, 12'h301, 5'd7, 5'd0);       // Odd base address
        jalr(5'd6, 5'd7, 12'h000);
        jalr(5'd6, 5'd7, 12'hFFC);
        idle();
    endtask

    task automatic test_errors();
        issue(32'h0000_007F, 1'b0, 1'b0, 5'd0, '0, '0);  // Unknown opcode
        issue(i_word(12'h0, 5'd1, 3'b001, 5'd2, secv_pkg::OPCODE_JALR),
              1'b0, 1'b0, 5'd0, '0, '0);
        alu_imm(3'd0, 12'd123, 5'd0, 5'd0);        // Pulses with address 0
        alu_reg(3'd0, 1'b0, 5'd8, 5'd0, 5'd0);
        idle();
    endtask

    task automatic test_random();
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        int          kind;
        pc_now = $urandom & 32'hFFFF_FFFC;
        for (int n = 0; n < 200; n++) begin
            kind = $urandom_range(2);
            rd   = $urandom_range(31);
            rs1  = $urandom_range(31);
            rs2  = $urandom_range(31);
            f3   = $urandom_range(7);
            alt  = $urandom_range(1);
            imm  = $urandom_range(12'hFFF);
            case (kind)
                0: alu_reg(f3, alt && (f3 == 3'd0 || f3 == 3'd5), rd, rs1, rs2);
                1: begin
                    if (f3 == 3'd1) imm[11:5] = 7'h00;  // Shift encodings
                    if (f3 == 3'd5) imm[11:5] = alt ? 7'h20 : 7'h00;
                    alu_imm(f3, imm, rd, rs1);
                end
                default: begin
                    if (alt) lui(rd, $urandom_range(20'hFFFFF));
                    else auipc(rd, $urandom_range(20'hFFFFF));
                end
            endcase
        end
        idle();
    endtask

    initial begin
        void'($urandom(22));
        rst_i      = 1'b1;
        ena_i      = 1'b0;
        inst_i     = '0;
        pc_i       = '0;
        pc_now     = '0;
        pend_valid = 1'b0;
        pend_err   = 1'b0;
        pend_wb    = 1'b0;
        pend_addr  = '0;
        pend_data  = '0;
        pend_npc   = '0;
        foreach (model[i]) model[i] = '0;
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        wait_outputs_idle();
        @(posedge clk_i);
        test_reset();
        test_move();
        test_alu();
        test_branch();
        test_errors();
        test_random();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* src.f */
hdl/secv_pkg.sv
hdl/decode.sv
hdl/regfile.sv
hdl/alu.sv
hdl/move.sv
hdl/branch.sv
hdl/secv_exec.sv
sim/tb_secv_exec.sv

/* Bender.yml */
package:
  name: secv_exec

sources:
  - files:
      - hdl/secv_pkg.sv
      - hdl/decode.sv
      - hdl/regfile.sv
      - hdl/alu.sv
      - hdl/move.sv
      - hdl/branch.sv
      - hdl/secv_exec.sv
  - target: simulation
    files:
      - sim/tb_secv_exec.sv
